// ==== include/mult_settings.svh ====
`ifndef MULT_SETTINGS_SVH
`define MULT_SETTINGS_SVH

// number of pipeline stages in the multiplier
// each stage handles MULT_XLEN / MULT_NUM_STAGES bits of the multiplier,
// so the value has to divide 64 (4, 8 and 16 are the usual choices)
`define MULT_NUM_STAGES 8

// operand and result width of the unit
`define MULT_XLEN 64

// width of the destination tag that rides along with each operation
// this matches the physical register tag of the core
`define MULT_TAG_BITS 6

`endif

// ==== source/mult_pkg.sv ====
`default_nettype none

`include "mult_settings.svh"

package mult_pkg;

	// the two supported opcodes
	// mulw works on the full product and keeps only the low word
	typedef enum logic {
		mult_op_mul  = 1'b0,
		mult_op_mulw = 1'b1
	} mult_op_e;

	// bookkeeping that travels beside the data through every stage
	typedef struct packed {
		logic [`MULT_TAG_BITS-1:0] tag;
		mult_op_e                  op;
	} mult_meta_t;

	// one issue packet from the scheduler
	// a is the multiplicand and b the multiplier
	typedef struct packed {
		mult_meta_t            meta;
		logic [`MULT_XLEN-1:0] a;
		logic [`MULT_XLEN-1:0] b;
	} mult_issue_t;

	// what goes back to the writeback bus of the core
	typedef struct packed {
		logic [`MULT_TAG_BITS-1:0] tag;
		logic [`MULT_XLEN-1:0]     value;
	} mult_result_t;

endpackage

`default_nettype wire

// ==== source/mult_stage.sv ====
`default_nettype none

`include "mult_settings.svh"

module mult_stage #(
	parameter int NUM_STAGES = `MULT_NUM_STAGES
) (
	input  wire logic                  clock,
	input  wire logic                  reset,
	input  wire logic                  start,
	input  wire logic [`MULT_XLEN-1:0] product_in,
	input  wire logic [`MULT_XLEN-1:0] mplier_in,
	input  wire logic [`MULT_XLEN-1:0] mcand_in,
	input  wire mult_pkg::mult_meta_t  meta_in,
	output logic                       done,
	output logic [`MULT_XLEN-1:0]      product_out,
	output logic [`MULT_XLEN-1:0]      mplier_out,
	output logic [`MULT_XLEN-1:0]      mcand_out,
	output mult_pkg::mult_meta_t       meta_out
);

	import mult_pkg::*;

	// number of multiplier bits consumed by this stage
	localparam int SLICE = `MULT_XLEN / NUM_STAGES;

	// running product from the previous stage held for one cycle
	logic [`MULT_XLEN-1:0] prod_in_reg;
	// this stage's contribution is already aligned by the shifted multiplicand
	logic [`MULT_XLEN-1:0] partial_prod_reg;

	logic [`MULT_XLEN-1:0] partial_product;
	logic [`MULT_XLEN-1:0] next_mplier;
	logic [`MULT_XLEN-1:0] next_mcand;

	// the low slice of the multiplier times the whole multiplicand
	// only the low XLEN bits matter because the upper half is never returned
	assign partial_product = `MULT_XLEN'(mplier_in[SLICE-1:0]) * mcand_in;

	// move on to the next slice for the following stage
	// the multiplicand moves left so its weight lines up with that slice
	assign next_mplier = mplier_in >> SLICE;
	assign next_mcand  = mcand_in << SLICE;

	// the adder sits after the registers, so the sum is ready in the cycle
	// where done is high and feeds straight into the next stage's register
	assign product_out = prod_in_reg + partial_prod_reg;

	// datapath and metadata registers
	always_ff @(posedge clock) begin
		prod_in_reg      <= product_in;
		partial_prod_reg <= partial_product;
		mplier_out       <= next_mplier;
		mcand_out        <= next_mcand;
		meta_out         <= meta_in;
	end

	// done follows start one cycle later and drops on reset
	always_ff @(posedge clock) begin
		if (reset) begin
			done <= 1'b0;
		end else begin
			done <= start;
		end
	end

	// the slices have to tile the multiplier exactly, otherwise the top bits
	// of operand b are silently dropped
	slice_divides_xlen: assert property (
		@(posedge clock) (`MULT_XLEN % NUM_STAGES) == 0
	);

endmodule

`default_nettype wire

// ==== source/multiplier.sv ====
`default_nettype none

`include "mult_settings.svh"

module multiplier #(
	parameter int NUM_STAGES = `MULT_NUM_STAGES
) (
	input  wire logic                  clock,
	input  wire logic                  reset,
	input  wire logic                  start,
	input  wire logic [`MULT_XLEN-1:0] mcand,
	input  wire logic [`MULT_XLEN-1:0] mplier,
	input  wire mult_pkg::mult_meta_t  meta_in,
	output logic [`MULT_XLEN-1:0]      product,
	output logic                       done,
	output mult_pkg::mult_meta_t       meta_out
);

	import mult_pkg::*;

	// index i is the input of stage i and index NUM_STAGES is the output of
	// the last stage
	logic [NUM_STAGES:0]   stage_start;
	logic [`MULT_XLEN-1:0] stage_product [0:NUM_STAGES];
	logic [`MULT_XLEN-1:0] stage_mplier  [0:NUM_STAGES];
	logic [`MULT_XLEN-1:0] stage_mcand   [0:NUM_STAGES];
	mult_meta_t            stage_meta    [0:NUM_STAGES];

	// the first stage starts from an empty running product
	assign stage_start[0]   = start;
	assign stage_product[0] = '0;
	assign stage_mplier[0]  = mplier;
	assign stage_mcand[0]   = mcand;
	assign stage_meta[0]    = meta_in;

	genvar i;
	generate
		for (i = 0; i < NUM_STAGES; i++) begin : g_stage
			mult_stage #(
				.NUM_STAGES(NUM_STAGES)
			) i_mult_stage (
				.clock      (clock),
				.reset      (reset),
				.start      (stage_start[i]),
				.product_in (stage_product[i]),
				.mplier_in  (stage_mplier[i]),
				.mcand_in   (stage_mcand[i]),
				.meta_in    (stage_meta[i]),
				.done       (stage_start[i+1]),
				.product_out(stage_product[i+1]),
				.mplier_out (stage_mplier[i+1]),
				.mcand_out  (stage_mcand[i+1]),
				.meta_out   (stage_meta[i+1])
			);
		end
	endgenerate

	// the last stage drives the writeback
	assign product  = stage_product[NUM_STAGES];
	assign done     = stage_start[NUM_STAGES];
	assign meta_out = stage_meta[NUM_STAGES];

endmodule

`default_nettype wire

// ==== source/mult_writeback.sv ====
`default_nettype none

`include "mult_settings.svh"

module mult_writeback (
	input  wire logic                  clock,
	input  wire logic                  reset,
	input  wire logic                  done,
	input  wire logic [`MULT_XLEN-1:0] product,
	input  wire mult_pkg::mult_meta_t  meta,
	output logic                       result_valid,
	output mult_pkg::mult_result_t     result
);

	import mult_pkg::*;

	// a w-suffixed operation works on half of the register width
	localparam int WORD = `MULT_XLEN / 2;

	// value after opcode formatting and before the output register
	logic [`MULT_XLEN-1:0] formatted;

	// mul keeps the low XLEN bits as they come out of the multiplier
	// mulw keeps the low word and copies its sign bit upward
	always_comb begin
		case (meta.op)
			mult_op_mulw: begin
				formatted = {{(`MULT_XLEN - WORD){product[WORD-1]}}, product[WORD-1:0]};
			end
			default: begin
				formatted = product;
			end
		endcase
	end

	// payload only loads on a finished operation, so the last result stays
	// on the bus between pulses
	always_ff @(posedge clock) begin
		if (done) begin
			result.tag   <= meta.tag;
			result.value <= formatted;
		end
	end

	// one pulse per finished operation since there is no stall path
	always_ff @(posedge clock) begin
		if (reset) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= done;
		end
	end

endmodule

`default_nettype wire

// ==== source/mult_inflight_counter.sv ====
`default_nettype none

`include "mult_settings.svh"

module mult_inflight_counter #(
	parameter int NUM_STAGES = `MULT_NUM_STAGES
) (
	input  wire logic                           clock,
	input  wire logic                           reset,
	input  wire logic                           issue_valid,
	input  wire logic                           result_valid,
	output logic [$clog2(NUM_STAGES + 2)-1:0]   inflight_count,
	output logic                                idle
);

	// the pipeline holds NUM_STAGES operations plus one in writeback
	localparam int MAX_INFLIGHT = NUM_STAGES + 1;

	logic [$clog2(NUM_STAGES + 2)-1:0] next_count;

	// an issue and a result on the same cycle cancel out
	always_comb begin
		case ({issue_valid, result_valid})
			2'b10:   next_count = inflight_count + 1'b1;
			2'b01:   next_count = inflight_count - 1'b1;
			default: next_count = inflight_count;
		endcase
	end

	// idle comes from the next count, so it changes on the same edge as
	// the counter and the issue logic sees both agree
	always_ff @(posedge clock) begin
		if (reset) begin
			inflight_count <= '0;
			idle           <= 1'b1;
		end else begin
			inflight_count <= next_count;
			idle           <= (next_count == '0);
		end
	end

	// a result with nothing outstanding means the pipeline made one up
	no_underflow: assert property (
		@(posedge clock) disable iff (reset)
		(result_valid && !issue_valid) |-> (inflight_count != '0)
	);

	// more than the pipeline depth in flight means a result pulse was lost
	no_overflow: assert property (
		@(posedge clock) disable iff (reset)
		inflight_count <= MAX_INFLIGHT
	);

endmodule

`default_nettype wire

// ==== source/mult_unit.sv ====
`default_nettype none

`include "mult_settings.svh"

module mult_unit (
	input  wire logic                                clock,
	input  wire logic                                reset,
	input  wire logic                                issue_valid,
	input  wire mult_pkg::mult_issue_t               issue,
	output logic                                     result_valid,
	output mult_pkg::mult_result_t                   result,
	output logic [$clog2(`MULT_NUM_STAGES + 2)-1:0]  inflight_count,
	output logic                                     idle
);

	import mult_pkg::*;

	// multiplier to writeback
	logic                  mult_done;
	logic [`MULT_XLEN-1:0] mult_product;
	mult_meta_t            mult_meta;

	// operand a is the multiplicand and operand b the multiplier
	multiplier #(
		.NUM_STAGES(`MULT_NUM_STAGES)
	) i_multiplier (
		.clock   (clock),
		.reset   (reset),
		.start   (issue_valid),
		.mcand   (issue.a),
		.mplier  (issue.b),
		.meta_in (issue.meta),
		.product (mult_product),
		.done    (mult_done),
		.meta_out(mult_meta)
	);

	mult_writeback i_mult_writeback (
		.clock       (clock),
		.reset       (reset),
		.done        (mult_done),
		.product     (mult_product),
		.meta        (mult_meta),
		.result_valid(result_valid),
		.result      (result)
	);

	// the status counter for the issue logic watches both ends of the pipeline
	mult_inflight_counter #(
		.NUM_STAGES(`MULT_NUM_STAGES)
	) i_mult_inflight_counter (
		.clock         (clock),
		.reset         (reset),
		.issue_valid   (issue_valid),
		.result_valid  (result_valid),
		.inflight_count(inflight_count),
		.idle          (idle)
	);

endmodule

`default_nettype wire

// ==== sim/mult_unit_tb.sv ====
`default_nettype none

`include "mult_settings.svh"

module mult_unit_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import mult_pkg::*;

	localparam int NUM_STAGES = `MULT_NUM_STAGES;
	localparam int COUNT_BITS = $clog2(NUM_STAGES + 2);

	// one outstanding operation as the reference model sees it
	typedef struct packed {
		logic [`MULT_XLEN-1:0]     value;
		logic [`MULT_TAG_BITS-1:0] tag;
		logic [31:0]               due;
	} expected_t;

	logic                  clock;
	logic                  reset = 1'b1;
	logic                  issue_valid = 1'b0;
	mult_issue_t           issue = '0;
	logic                  result_valid;
	mult_result_t          result;
	logic [COUNT_BITS-1:0] inflight_count;
	logic                  idle;

	// reference model state, the head of the queue is the next result due
	expected_t             expected_q[$];
	logic [COUNT_BITS-1:0] expected_count = '0;
	logic [`MULT_XLEN-1:0] expected_value = '0;
	logic [`MULT_TAG_BITS-1:0] expected_tag = '0;
	logic [31:0]           expected_due = '0;
	logic [31:0]           cycle = '0;

	logic [31:0]           lfsr_state = 32'd93538;
	logic [`MULT_TAG_BITS-1:0] next_tag = '0;

	mult_unit i_mult_unit (
		.clock         (clock),
		.reset         (reset),
		.issue_valid   (issue_valid),
		.issue         (issue),
		.result_valid  (result_valid),
		.result        (result),
		.inflight_count(inflight_count),
		.idle          (idle)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// maximal length 32-bit Fibonacci LFSR, taps at 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	// one LFSR step for every bit handed out
	function automatic logic [63:0] random_bits(input int count);
		logic [63:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[62:0], lfsr_state[31]};
		end
		return value;
	endfunction

	// operands lean toward the corner cases that break carry chains
	function automatic logic [`MULT_XLEN-1:0] pick_operand();
		logic [2:0] kind;
		kind = 3'(random_bits(3));
		case (kind)
			3'd0:    return '0;
			3'd1:    return '1;
			3'd2:    return {1'b1, 63'(random_bits(63))};
			3'd3:    return `MULT_XLEN'(random_bits(32));
			default: return random_bits(64);
		endcase
	endfunction

	// puts one packet on the issue port, it stays valid until the next drive
	task automatic send_op(input mult_op_e op, input logic [`MULT_XLEN-1:0] a,
			input logic [`MULT_XLEN-1:0] b);
		mult_issue_t packet;
		packet.meta.tag = next_tag;
		packet.meta.op  = op;
		packet.a        = a;
		packet.b        = b;
		@(posedge clock);
		issue_valid <= 1'b1;
		issue       <= packet;
		next_tag     = next_tag + 1'b1;
	endtask

	task automatic send_gap(input int cycles);
		repeat (cycles) begin
			@(posedge clock);
			issue_valid <= 1'b0;
		end
	endtask

	task automatic send_random_op();
		mult_op_e op;
		op = mult_op_e'(random_bits(1));
		next_tag = `MULT_TAG_BITS'(random_bits(`MULT_TAG_BITS));
		send_op(op, pick_operand(), pick_operand());
	endtask

	// reset in the middle of traffic, whatever is in flight is dropped
	task automatic apply_reset(input int cycles);
		@(posedge clock);
		reset       <= 1'b1;
		issue_valid <= 1'b0;
		repeat (cycles) @(posedge clock);
		reset <= 1'b0;
	endtask

	// stops issuing and waits on the falling edge until nothing is outstanding
	task automatic wait_drain(input int limit);
		int   waited;
		logic drained;
		waited  = 0;
		drained = 1'b0;
		@(posedge clock);
		issue_valid <= 1'b0;
		while (!drained && waited < limit) begin
			@(negedge clock);
			waited++;
			drained = (expected_count == '0) && idle;
		end
		if (!drained) begin
			$display("the unit did not drain within %0d cycles", limit);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	// reference model, watches the port at the same edge the DUT samples it
	always @(posedge clock) begin : track_expected
		expected_t            entry;
		logic [`MULT_XLEN-1:0] full_product;
		if (reset) begin
			expected_q.delete();
		end else begin
			// pop first so an empty queue never sees its own new entry retire
			if (result_valid && expected_q.size() > 0) begin
				void'(expected_q.pop_front());
			end
			if (issue_valid) begin
				full_product = issue.a * issue.b;
				if (issue.meta.op == mult_op_mulw) begin
					entry.value = `MULT_XLEN'($signed(full_product[31:0]));
				end else begin
					entry.value = full_product;
				end
				entry.tag = issue.meta.tag;
				entry.due = cycle + NUM_STAGES + 1;
				expected_q.push_back(entry);
			end
		end
		expected_count <= COUNT_BITS'(expected_q.size());
		if (expected_q.size() > 0) begin
			expected_value <= expected_q[0].value;
			expected_tag   <= expected_q[0].tag;
			expected_due   <= expected_q[0].due;
		end
		cycle <= cycle + 1;
	end

	no_extra_pulse: assert property (@(posedge clock)
		(!reset && result_valid) |-> (expected_count != '0))
	else begin
		$display("a result pulse arrived at %0t with no operation outstanding", $time);
		$display("Some tests failed");
		$fatal(1);
	end

	no_missing_pulse: assert property (@(posedge clock)
		(!reset && expected_count != '0 && cycle == expected_due) |-> result_valid)
	else begin
		$display("no result pulse at %0t for the operation with tag %h",
			$time, $sampled(expected_tag));
		$display("Some tests failed");
		$fatal(1);
	end

	result_on_time: assert property (@(posedge clock)
		(!reset && result_valid && expected_count != '0) |-> (cycle == expected_due))
	else begin
		$display("MISMATCH at %0t: result arrived in cycle %0d, expected cycle %0d",
			$time, $sampled(cycle), $sampled(expected_due));
		$display("Some tests failed");
		$fatal(1);
	end

	result_tag_matches: assert property (@(posedge clock)
		(!reset && result_valid && expected_count != '0) |-> (result.tag == expected_tag))
	else begin
		$display("MISMATCH at %0t: result tag %h, expected %h",
			$time, $sampled(result.tag), $sampled(expected_tag));
		$display("Some tests failed");
		$fatal(1);
	end

	result_value_matches: assert property (@(posedge clock)
		(!reset && result_valid && expected_count != '0) |-> (result.value == expected_value))
	else begin
		$display("MISMATCH at %0t: result value %h for tag %h, expected %h",
			$time, $sampled(result.value), $sampled(result.tag), $sampled(expected_value));
		$display("Some tests failed");
		$fatal(1);
	end

	// the counter and the queue both move on the edge that sees a strobe
	count_matches: assert property (@(posedge clock)
		!reset |-> (inflight_count == expected_count))
	else begin
		$display("MISMATCH at %0t: inflight_count %0d, expected %0d",
			$time, $sampled(inflight_count), $sampled(expected_count));
		$display("Some tests failed");
		$fatal(1);
	end

	idle_matches: assert property (@(posedge clock)
		!reset |-> (idle == (expected_count == '0)))
	else begin
		$display("MISMATCH at %0t: idle %b with %0d operations outstanding",
			$time, $sampled(idle), $sampled(expected_count));
		$display("Some tests failed");
		$fatal(1);
	end

	// a hung stimulus loop still ends the run
	initial begin : watchdog
		repeat (20000) @(posedge clock);
		$display("the simulation did not finish within the cycle limit");
		$display("Some tests failed");
		$fatal(1);
	end

	initial begin
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		wait_drain(4);

		// corner operands for mul, zero, all ones and the top bit
		send_op(mult_op_mul, '0, 64'h1234_5678_9abc_def0);
		send_op(mult_op_mul, '1, '1);
		send_op(mult_op_mul, 64'h8000_0000_0000_0000, 64'd3);
		send_op(mult_op_mul, 64'hffff_ffff_ffff_fffe, 64'h8000_0000_0000_0001);
		send_op(mult_op_mul, 64'h0000_0001_0000_0001, 64'hffff_ffff_0000_0003);
		wait_drain(4 * NUM_STAGES);

		// mulw with a positive and a negative low word
		send_op(mult_op_mulw, 64'd3, 64'd5);
		send_op(mult_op_mulw, 64'h0000_0000_ffff_ffff, 64'd1);
		send_op(mult_op_mulw, 64'h0000_0000_7fff_ffff, 64'd2);
		send_op(mult_op_mulw, 64'hdead_beef_0000_1000, 64'h0000_0000_0008_0000);
		send_op(mult_op_mulw, '1, '1);
		wait_drain(4 * NUM_STAGES);

		// a long back-to-back burst fills every stage and the writeback
		repeat (3 * NUM_STAGES) send_random_op();
		wait_drain(4 * NUM_STAGES);

		// random traffic with random gaps between issues
		repeat (300) begin
			send_random_op();
			if (random_bits(2) == '0) begin
				send_gap(1 + int'(random_bits(2)));
			end
		end
		wait_drain(4 * NUM_STAGES);

		// reset with a full pipeline, nothing issued before it may come out
		repeat (NUM_STAGES) send_random_op();
		apply_reset(3);
		wait_drain(4 * NUM_STAGES);

		// reset with only a few operations in flight, then normal traffic again
		repeat (3) send_random_op();
		send_gap(2);
		apply_reset(1);
		repeat (2 * NUM_STAGES) send_random_op();
		wait_drain(4 * NUM_STAGES);

		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== mult_unit.f ====
+incdir+include
source/mult_pkg.sv
source/mult_stage.sv
source/multiplier.sv
source/mult_writeback.sv
source/mult_inflight_counter.sv
source/mult_unit.sv
sim/mult_unit_tb.sv

// ==== mult_unit.sh ====
#!/bin/sh
# build and run the multiply unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mult_unit_tb \
	-f mult_unit.f -o mult_unit_sim > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/mult_unit_sim > sim.log 2>&1
cat sim.log

grep -q "Some tests failed" sim.log && exit 1
grep -q "All tests passed" sim.log || exit 1
exit 0
